/* design/mac_glue_pkg.sv */
//======================================================================
// Shared types and constants for the 68000 computer glue subsystem.
// Holds the bus widths, the SDRAM layout of the downloaded images and
// the floppy image sizes. Modules name these types by scope in their
// port lists and import the package in the body where they need it.
//======================================================================

package mac_glue_pkg;

  // SDRAM side
  typedef logic [24:0] mem_addr_t;
  typedef logic [15:0] word_t;

  // Host download side
  typedef logic [7:0]  byte_t;
  typedef logic [24:0] dl_addr_t;
  typedef logic [7:0]  img_index_t;

  // Word offset inside the 2M-word image area
  typedef logic [20:0] img_addr_t;

  // Configured RAM size, 0 to 3
  typedef logic [1:0]  ram_size_t;

  //====================================================================
  // Image layout
  //====================================================================

  // Floppy images follow the OS ROM at 512K and 1M words
  localparam img_addr_t IMG_BASE_INT = 21'h080000;
  localparam img_addr_t IMG_BASE_EXT = 21'h100000;

  // Upper address bits of every download write
  localparam logic [3:0] IMG_REGION = 4'b0001;

  // Final word address of a complete 800K or 400K image
  localparam logic [23:0] DSK_WORDS_DS = 24'd409600;
  localparam logic [23:0] DSK_WORDS_SS = 24'd204800;

endpackage

/* design/mem_req_if.sv */
//======================================================================
// One SDRAM request, driven by the image loader and consumed by the
// SDRAM port multiplexer during download slots.
//======================================================================

`timescale 1ns/1ps

interface mem_req_if;

  mac_glue_pkg::mem_addr_t addr;
  mac_glue_pkg::word_t     wdata;
  logic [1:0]              ds;
  logic                    we;
  logic                    oe;

  // Request source
  modport loader (
    output addr, wdata, ds, we, oe
  );

  // Request sink
  modport mux (
    input addr, wdata, ds, we, oe
  );

endinterface

/* design/clk_reset_gen.sv */
//======================================================================
// Clock enables and system reset for the glue subsystem.
// A free running divide-by-eight gives three phased enables. Any reset
// source reloads a delay counter that runs down on cen, and the system
// reset is released one cycle after it reaches zero.
//======================================================================

`timescale 1ns/1ps

module clk_reset_gen #(
  parameter int RESET_BITS = 16
) (
  input  logic                    clk_sys,
  input  logic                    RESET,
  input  logic                    reset_req_i,
  input  logic                    cpu_reset_out_n_i,
  input  mac_glue_pkg::ram_size_t ram_size_sel_i,
  output logic                    cep_o,
  output logic                    cen_o,
  output logic                    cel_o,
  output logic                    sys_reset_n_o,
  output mac_glue_pkg::ram_size_t ram_size_o
);

  logic [2:0]            div;
  logic [4:0]            reset_pipe;
  logic                  reset_src;
  logic [RESET_BITS-1:0] rst_cnt;

  // Enables at phases 0, 4 and 7, one cycle behind the count
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      div   <= '0;
      cep_o <= 1'b0;
      cen_o <= 1'b0;
      cel_o <= 1'b0;
    end else begin
      div   <= div + 3'd1;
      cep_o <= (div == 3'd0);
      cen_o <= (div == 3'd4);
      cel_o <= (div == 3'd7);
    end
  end

  // Five stage release of the external reset
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      reset_pipe <= '1;
    end else begin
      reset_pipe <= {reset_pipe[3:0], 1'b0};
    end
  end

  assign reset_src = reset_pipe[4] | ~cpu_reset_out_n_i | reset_req_i;

  // RAM size is sampled only while the delay is running
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
      ram_size_o    <= '0;
    end else if (reset_src) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
    end else if (|rst_cnt) begin
      if (cen_o) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      ram_size_o <= ram_size_sel_i + 2'd1;
    end else begin
      sys_reset_n_o <= 1'b1;
    end
  end

endmodule

/* design/image_loader.sv */
//======================================================================
// Boot ROM and floppy image download path.
// Pairs host bytes into SDRAM words, holds the host off with the wait
// flag until the word has had a full memory slot, and maps the image
// index onto its own SDRAM region.
//======================================================================

`timescale 1ns/1ps

module image_loader (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  logic                     dl_wr_i,
  input  mac_glue_pkg::dl_addr_t   dl_addr_i,
  input  mac_glue_pkg::byte_t      dl_data_i,
  input  mac_glue_pkg::img_index_t dl_index_i,
  input  logic                     dl_slot_i,
  output logic                     dl_wait_o,
  mem_req_if.loader                req
);

  import mac_glue_pkg::*;

  byte_t     even_byte;
  word_t     word_q;
  logic      old_slot;
  logic      slot_fall;
  logic      write_req;
  img_addr_t word_off;
  img_addr_t img_addr;

  assign slot_fall = old_slot & ~dl_slot_i;

  // Byte pairing, even byte goes to the high half
  always_ff @(posedge clk_sys) begin
    if (dl_wr_i) begin
      if (!dl_addr_i[0]) begin
        even_byte <= dl_data_i;
      end else begin
        word_q <= {even_byte, dl_data_i};
      end
    end
  end

  // Wait and write flags against the slot edges
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      old_slot  <= 1'b0;
      write_req <= 1'b0;
      dl_wait_o <= 1'b0;
    end else begin
      old_slot <= dl_slot_i;
      if (!dl_slot_i) begin
        write_req <= dl_wait_o;
      end
      if (dl_wr_i && dl_addr_i[0]) begin
        dl_wait_o <= 1'b1;
      end
      // Word has been written in the slot that just ended
      if (slot_fall && write_req) begin
        dl_wait_o <= 1'b0;
      end
    end
  end

  //====================================================================
  // Address mapping
  //====================================================================

  assign word_off = dl_addr_i[21:1];

  always_comb begin
    case (dl_index_i)
      img_index_t'(0): img_addr = word_off;
      img_index_t'(1): img_addr = IMG_BASE_INT + word_off;
      default:         img_addr = IMG_BASE_EXT + word_off;
    endcase
  end

  assign req.addr  = {IMG_REGION, img_addr};
  assign req.wdata = word_q;
  assign req.ds    = 2'b11;
  assign req.we    = write_req;
  assign req.oe    = 1'b0;

endmodule

/* design/disk_presence.sv */
//======================================================================
// Floppy image presence for the internal and external drive.
// When a download ends, the final word address tells a double sided
// image from a single sided one. The drive's eject bit clears both.
//======================================================================

`timescale 1ns/1ps

module disk_presence (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  logic                     dl_active_i,
  input  mac_glue_pkg::img_index_t dl_index_i,
  input  mac_glue_pkg::dl_addr_t   dl_addr_i,
  input  logic [1:0]               disk_eject_i,
  output logic [1:0]               disk_ds_o,
  output logic [1:0]               disk_ss_o
);

  import mac_glue_pkg::*;

  logic        old_active;
  logic        dl_fall;
  logic [23:0] word_addr;

  assign dl_fall   = old_active & ~dl_active_i;
  assign word_addr = dl_addr_i[24:1];

  // Drive 0 takes index 1, drive 1 takes index 2
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      old_active <= 1'b0;
      disk_ds_o  <= '0;
      disk_ss_o  <= '0;
    end else begin
      old_active <= dl_active_i;
      for (int d = 0; d < 2; d++) begin
        if (dl_fall && dl_index_i == img_index_t'(d + 1)) begin
          disk_ds_o[d] <= (word_addr == DSK_WORDS_DS);
          disk_ss_o[d] <= (word_addr == DSK_WORDS_SS);
        end
        if (disk_eject_i[d]) begin
          disk_ds_o[d] <= 1'b0;
          disk_ss_o[d] <= 1'b0;
        end
      end
    end
  end

endmodule

/* design/sdram_mux.sv */
//======================================================================
// SDRAM port multiplexer.
// Download requests own the port during the download slot, otherwise
// the CPU side memory strobes drive it. Disk reads get their byte
// repeated in both halves of the returned word.
//======================================================================

`timescale 1ns/1ps

module sdram_mux (
  input  logic                    dl_active_i,
  input  logic                    dl_slot_i,
  mem_req_if.mux                  req,
  input  logic [21:0]             cpu_addr_i,
  input  logic                    cpu_rom_oe_n_i,
  input  logic                    cpu_ram_oe_n_i,
  input  logic                    cpu_ram_we_n_i,
  input  logic                    cpu_uds_n_i,
  input  logic                    cpu_lds_n_i,
  input  mac_glue_pkg::word_t     cpu_wdata_i,
  input  logic                    dsk_ack_i,
  input  mac_glue_pkg::word_t     sdram_rdata_i,
  output mac_glue_pkg::mem_addr_t sdram_addr_o,
  output mac_glue_pkg::word_t     sdram_wdata_o,
  output logic [1:0]              sdram_ds_o,
  output logic                    sdram_we_o,
  output logic                    sdram_oe_o,
  output mac_glue_pkg::word_t     cpu_rdata_o
);

  import mac_glue_pkg::*;

  logic  dl_cycle;
  word_t dsk_byte;

  assign dl_cycle = dl_active_i & dl_slot_i;

  // Odd addresses read the low byte
  assign dsk_byte = cpu_addr_i[0] ? {2{sdram_rdata_i[7:0]}} : {2{sdram_rdata_i[15:8]}};

  // ROM select sits just above the 21-bit word address
  assign sdram_addr_o  = dl_cycle ? req.addr : {3'b000, ~cpu_rom_oe_n_i, cpu_addr_i[21:1]};
  assign sdram_wdata_o = dl_cycle ? req.wdata : cpu_wdata_i;
  assign sdram_ds_o    = dl_cycle ? req.ds : {~cpu_uds_n_i, ~cpu_lds_n_i};
  assign sdram_we_o    = dl_cycle ? req.we : ~cpu_ram_we_n_i;
  assign sdram_oe_o    = dl_cycle ? req.oe : (~cpu_ram_oe_n_i | ~cpu_rom_oe_n_i);

  assign cpu_rdata_o = dl_cycle  ? 16'hffff :
                       dsk_ack_i ? dsk_byte : sdram_rdata_i;

endmodule

/* design/turbo_gate.sv */
//======================================================================
// Turbo enable and activity LED.
// Turbo is held off until a number of SD transfers have completed so
// that a SCSI boot can finish. The LED shows download activity, or
// stretched disk activity against the motor state.
//======================================================================

`timescale 1ns/1ps

module turbo_gate #(
  parameter int TURBO_ACKS = 20
) (
  input  logic clk_sys,
  input  logic RESET,
  input  logic sys_reset_n_i,
  input  logic turbo_req_i,
  input  logic sd_ack_i,
  input  logic disk_motor_i,
  input  logic dl_slot_i,
  input  logic disk_act_i,
  input  logic dl_active_i,
  output logic turbo_o,
  output logic led_o
);

  localparam int CNT_W    = $clog2(TURBO_ACKS + 1);
  localparam int LED_HOLD = 1_000_000;

  logic             old_ack;
  logic [CNT_W-1:0] ack_cnt;
  logic [19:0]      act_cnt;
  logic             act_led;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      old_ack <= 1'b0;
      ack_cnt <= CNT_W'(TURBO_ACKS);
      turbo_o <= 1'b0;
    end else begin
      old_ack <= sd_ack_i;
      if (old_ack && !sd_ack_i && |ack_cnt) begin
        ack_cnt <= ack_cnt - 1'b1;
      end
      // Floppy access ends the delay at once
      if (disk_motor_i) begin
        ack_cnt <= '0;
      end
      if (ack_cnt == '0 && dl_slot_i) begin
        turbo_o <= turbo_req_i;
      end
      if (!sys_reset_n_i) begin
        turbo_o <= 1'b0;
        ack_cnt <= CNT_W'(TURBO_ACKS);
      end
    end
  end

  // Activity stretch
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      act_cnt <= '0;
      act_led <= 1'b0;
    end else begin
      act_led <= |act_cnt;
      if (|act_cnt) begin
        act_cnt <= act_cnt - 1'b1;
      end
      if (disk_act_i) begin
        act_cnt <= 20'(LED_HOLD);
      end
    end
  end

  assign led_o = dl_active_i | (act_led ^ disk_motor_i);

endmodule

/* design/mac_glue_top.sv */
//======================================================================
// Glue logic around the 68000 core of a compact computer.
// Wires clock and reset generation, image download, floppy presence,
// the SDRAM port multiplexer and turbo gating to plain ports.
//======================================================================

`timescale 1ns/1ps

module mac_glue_top #(
  parameter int RESET_BITS = 16,
  parameter int TURBO_ACKS = 20
) (
  input  logic                     clk_sys,
  input  logic                     RESET,
  // Reset and configuration
  input  logic                     reset_req_i,
  input  logic                     cpu_reset_out_n_i,
  input  mac_glue_pkg::ram_size_t  ram_size_sel_i,
  output logic                     cep_o,
  output logic                     cen_o,
  output logic                     cel_o,
  output logic                     sys_reset_n_o,
  output mac_glue_pkg::ram_size_t  ram_size_o,
  // Host download
  input  logic                     dl_wr_i,
  input  mac_glue_pkg::dl_addr_t   dl_addr_i,
  input  mac_glue_pkg::byte_t      dl_data_i,
  input  mac_glue_pkg::img_index_t dl_index_i,
  input  logic                     dl_slot_i,
  input  logic                     dl_active_i,
  output logic                     dl_wait_o,
  // Floppy drives
  input  logic [1:0]               disk_eject_i,
  output logic [1:0]               disk_ds_o,
  output logic [1:0]               disk_ss_o,
  // CPU side memory access
  input  logic [21:0]              cpu_addr_i,
  input  logic                     cpu_rom_oe_n_i,
  input  logic                     cpu_ram_oe_n_i,
  input  logic                     cpu_ram_we_n_i,
  input  logic                     cpu_uds_n_i,
  input  logic                     cpu_lds_n_i,
  input  mac_glue_pkg::word_t      cpu_wdata_i,
  input  logic                     dsk_ack_i,
  output mac_glue_pkg::word_t      cpu_rdata_o,
  // SDRAM port
  input  mac_glue_pkg::word_t      sdram_rdata_i,
  output mac_glue_pkg::mem_addr_t  sdram_addr_o,
  output mac_glue_pkg::word_t      sdram_wdata_o,
  output logic [1:0]               sdram_ds_o,
  output logic                     sdram_we_o,
  output logic                     sdram_oe_o,
  // Turbo and LED
  input  logic                     turbo_req_i,
  input  logic                     sd_ack_i,
  input  logic                     disk_motor_i,
  input  logic                     disk_act_i,
  output logic                     turbo_o,
  output logic                     led_o
);

  mem_req_if dl_req ();

  clk_reset_gen #(
    .RESET_BITS (RESET_BITS)
  ) i_clk_reset_gen (
    .clk_sys           (clk_sys),
    .RESET             (RESET),
    .reset_req_i       (reset_req_i),
    .cpu_reset_out_n_i (cpu_reset_out_n_i),
    .ram_size_sel_i    (ram_size_sel_i),
    .cep_o             (cep_o),
    .cen_o             (cen_o),
    .cel_o             (cel_o),
    .sys_reset_n_o     (sys_reset_n_o),
    .ram_size_o        (ram_size_o)
  );

  image_loader i_image_loader (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .dl_wr_i    (dl_wr_i),
    .dl_addr_i  (dl_addr_i),
    .dl_data_i  (dl_data_i),
    .dl_index_i (dl_index_i),
    .dl_slot_i  (dl_slot_i),
    .dl_wait_o  (dl_wait_o),
    .req        (dl_req.loader)
  );

  disk_presence i_disk_presence (
    .clk_sys      (clk_sys),
    .RESET        (RESET),
    .dl_active_i  (dl_active_i),
    .dl_index_i   (dl_index_i),
    .dl_addr_i    (dl_addr_i),
    .disk_eject_i (disk_eject_i),
    .disk_ds_o    (disk_ds_o),
    .disk_ss_o    (disk_ss_o)
  );

  sdram_mux i_sdram_mux (
    .dl_active_i    (dl_active_i),
    .dl_slot_i      (dl_slot_i),
    .req            (dl_req.mux),
    .cpu_addr_i     (cpu_addr_i),
    .cpu_rom_oe_n_i (cpu_rom_oe_n_i),
    .cpu_ram_oe_n_i (cpu_ram_oe_n_i),
    .cpu_ram_we_n_i (cpu_ram_we_n_i),
    .cpu_uds_n_i    (cpu_uds_n_i),
    .cpu_lds_n_i    (cpu_lds_n_i),
    .cpu_wdata_i    (cpu_wdata_i),
    .dsk_ack_i      (dsk_ack_i),
    .sdram_rdata_i  (sdram_rdata_i),
    .sdram_addr_o   (sdram_addr_o),
    .sdram_wdata_o  (sdram_wdata_o),
    .sdram_ds_o     (sdram_ds_o),
    .sdram_we_o     (sdram_we_o),
    .sdram_oe_o     (sdram_oe_o),
    .cpu_rdata_o    (cpu_rdata_o)
  );

  turbo_gate #(
    .TURBO_ACKS (TURBO_ACKS)
  ) i_turbo_gate (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .sys_reset_n_i (sys_reset_n_o),
    .turbo_req_i   (turbo_req_i),
    .sd_ack_i      (sd_ack_i),
    .disk_motor_i  (disk_motor_i),
    .dl_slot_i     (dl_slot_i),
    .disk_act_i    (disk_act_i),
    .dl_active_i   (dl_active_i),
    .turbo_o       (turbo_o),
    .led_o         (led_o)
  );

endmodule

/* tests/tb_clk_gen.sv */
//======================================================================
// Clock and reset source for the glue subsystem testbench.
// Runs a free clock and holds reset high for a set number of cycles.
//======================================================================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD       = 100.0,
  parameter int      RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2.0) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

/* tests/tb_mac_glue.sv */
//======================================================================
// Testbench for the glue subsystem top level.
// Reads download and presence vectors from the data file, drives the
// DUT one nanosecond after each rising edge and samples its outputs
// on the falling edge. Slot timing comes from a seeded LCG.
//======================================================================

`timescale 1ns/1ps

module tb_mac_glue;

  import mac_glue_pkg::*;

  logic        clk_sys;
  logic        RESET;
  logic        reset_req_i;
  logic        cpu_reset_out_n_i;
  ram_size_t   ram_size_sel_i;
  logic        cep_o;
  logic        cen_o;
  logic        cel_o;
  logic        sys_reset_n_o;
  ram_size_t   ram_size_o;
  logic        dl_wr_i;
  dl_addr_t    dl_addr_i;
  byte_t       dl_data_i;
  img_index_t  dl_index_i;
  logic        dl_slot_i;
  logic        dl_active_i;
  logic        dl_wait_o;
  logic [1:0]  disk_eject_i;
  logic [1:0]  disk_ds_o;
  logic [1:0]  disk_ss_o;
  logic [21:0] cpu_addr_i;
  logic        cpu_rom_oe_n_i;
  logic        cpu_ram_oe_n_i;
  logic        cpu_ram_we_n_i;
  logic        cpu_uds_n_i;
  logic        cpu_lds_n_i;
  word_t       cpu_wdata_i;
  logic        dsk_ack_i;
  word_t       cpu_rdata_o;
  word_t       sdram_rdata_i;
  mem_addr_t   sdram_addr_o;
  word_t       sdram_wdata_o;
  logic [1:0]  sdram_ds_o;
  logic        sdram_we_o;
  logic        sdram_oe_o;
  logic        turbo_req_i;
  logic        sd_ack_i;
  logic        disk_motor_i;
  logic        disk_act_i;
  logic        turbo_o;
  logic        led_o;

  logic [31:0] vec [0:63];
  logic [31:0] lcg_state;
  int unsigned n_checks;

  tb_clk_gen #(.PERIOD(100.0), .RESET_CYCLES(10)) i_clk_gen (
    .clk_o   (clk_sys),
    .reset_o (RESET)
  );

  mac_glue_top #(.RESET_BITS(3), .TURBO_ACKS(4)) i_dut (.*);

  //====================================================================
  // Helpers
  //====================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      $display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // Next drive point, just after the rising edge
  task automatic step();
    @(posedge clk_sys);
    #1;
  endtask

  task automatic wait_reset_release(input string what);
    int n;
    n = 0;
    while (sys_reset_n_o !== 1'b1) begin
      @(negedge clk_sys);
      n++;
      if (n > 300) timeout_fail(what);
    end
  endtask

  //====================================================================
  // Test sequence
  //====================================================================

  initial begin
    int n;
    int base;
    int n_load;
    int n_pres;
    bit seen;
    logic [3:0] flags;
    mem_addr_t exp_addr;

    reset_req_i = 1'b0;
    cpu_reset_out_n_i = 1'b1;
    ram_size_sel_i = 2'd2;
    dl_wr_i = 1'b0;
    dl_addr_i = '0;
    dl_data_i = '0;
    dl_index_i = '0;
    dl_slot_i = 1'b0;
    dl_active_i = 1'b0;
    disk_eject_i = 2'b00;
    cpu_addr_i = '0;
    cpu_rom_oe_n_i = 1'b1;
    cpu_ram_oe_n_i = 1'b1;
    cpu_ram_we_n_i = 1'b1;
    cpu_uds_n_i = 1'b1;
    cpu_lds_n_i = 1'b1;
    cpu_wdata_i = '0;
    dsk_ack_i = 1'b0;
    sdram_rdata_i = '0;
    turbo_req_i = 1'b0;
    sd_ack_i = 1'b0;
    disk_motor_i = 1'b0;
    disk_act_i = 1'b0;
    lcg_state = 32'hc55e_3be4;
    n_checks = 0;
    $readmemh("tests/loader_input.txt", vec);
    n_load = int'(vec[0]);
    n_pres = int'(vec[1]);

    // Clock enables and reset
    wait_reset_release("system reset release");
    check_eq("dl_wait after reset", 32'(1'b0), 32'(dl_wait_o));
    // Selection 2 gives size code 3
    check_eq("ram size", 32'(2'd3), 32'(ram_size_o));
    n = 0;
    while (cep_o !== 1'b1) begin
      @(negedge clk_sys);
      n++;
      if (n > 20) timeout_fail("cep pulse");
    end
    for (int k = 0; k < 8; k++) begin
      check_eq($sformatf("cep phase %0d", k), 32'(k == 0), 32'(cep_o));
      check_eq($sformatf("cen phase %0d", k), 32'(k == 4), 32'(cen_o));
      check_eq($sformatf("cel phase %0d", k), 32'(k == 7), 32'(cel_o));
      @(negedge clk_sys);
    end

    // Download mapping
    step();
    dl_active_i = 1'b1;
    for (int v = 0; v < n_load; v++) begin
      base = 2 + v * 6;
      step();
      dl_index_i = img_index_t'(vec[base]);
      dl_addr_i = dl_addr_t'(vec[base + 1]);
      dl_data_i = byte_t'(vec[base + 2]);
      dl_wr_i = 1'b1;
      dl_slot_i = 1'b0;
      step();
      dl_addr_i = dl_addr_t'(vec[base + 1] + 32'd1);
      dl_data_i = byte_t'(vec[base + 3]);
      @(negedge clk_sys);
      check_eq("dl_wait before odd byte", 32'(1'b0), 32'(dl_wait_o));
      step();
      dl_wr_i = 1'b0;
      @(negedge clk_sys);
      check_eq("dl_wait after odd byte", 32'(1'b1), 32'(dl_wait_o));
      seen = 1'b0;
      n = 0;
      while (1) begin
        step();
        lcg_state = lcg_next(lcg_state);
        dl_slot_i = lcg_state[16];
        @(negedge clk_sys);
        if (dl_slot_i) begin
          check_eq("download we", 32'(1'b1), 32'(sdram_we_o));
          check_eq("download addr", vec[base + 4], 32'(sdram_addr_o));
          check_eq("download word", vec[base + 5], 32'(sdram_wdata_o));
          check_eq("download ds", 32'(2'b11), 32'(sdram_ds_o));
          seen = 1'b1;
        end
        if (dl_wait_o === 1'b0) begin
          check_eq("slot before wait release", 32'(1'b1), 32'(seen));
          break;
        end
        n++;
        if (n > 100) timeout_fail("download wait release");
      end
    end

    // Presence from the final download address
    for (int v = 0; v < n_pres; v++) begin
      base = 2 + (n_load + v) * 6;
      step();
      dl_slot_i = 1'b0;
      dl_active_i = 1'b1;
      dl_index_i = img_index_t'(vec[base]);
      dl_addr_i = dl_addr_t'(vec[base + 1]);
      step();
      dl_active_i = 1'b0;
      step();
      @(negedge clk_sys);
      flags = vec[base + 5][3:0];
      check_eq("presence flags", 32'(flags), 32'({disk_ds_o, disk_ss_o}));
    end
    for (int d = 0; d < 2; d++) begin
      step();
      disk_eject_i = 2'b01 << d;
      step();
      disk_eject_i = 2'b00;
      @(negedge clk_sys);
      flags = flags & ~{2'b01 << d, 2'b01 << d};
      check_eq("flags after eject", 32'(flags), 32'({disk_ds_o, disk_ss_o}));
    end

    // CPU path: ROM read, RAM write, disk byte reads
    step();
    cpu_addr_i = 22'h12345;
    cpu_rom_oe_n_i = 1'b0;
    cpu_uds_n_i = 1'b0;
    cpu_lds_n_i = 1'b0;
    @(negedge clk_sys);
    // Word 0x91a2 with the ROM select at bit 21
    exp_addr = 25'h20_91a2;
    check_eq("rom read addr", 32'(exp_addr), 32'(sdram_addr_o));
    check_eq("rom read oe", 32'(1'b1), 32'(sdram_oe_o));
    check_eq("rom read we", 32'(1'b0), 32'(sdram_we_o));
    check_eq("rom read ds", 32'(2'b11), 32'(sdram_ds_o));
    step();
    cpu_rom_oe_n_i = 1'b1;
    cpu_ram_we_n_i = 1'b0;
    cpu_uds_n_i = 1'b1;
    cpu_wdata_i = 16'h1234;
    @(negedge clk_sys);
    exp_addr = 25'h00_91a2;
    check_eq("ram write addr", 32'(exp_addr), 32'(sdram_addr_o));
    check_eq("ram write we", 32'(1'b1), 32'(sdram_we_o));
    check_eq("ram write oe", 32'(1'b0), 32'(sdram_oe_o));
    check_eq("ram write ds", 32'(2'b01), 32'(sdram_ds_o));
    check_eq("ram write data", 32'(16'h1234), 32'(sdram_wdata_o));
    step();
    cpu_ram_we_n_i = 1'b1;
    cpu_ram_oe_n_i = 1'b0;
    sdram_rdata_i = 16'ha55a;
    dsk_ack_i = 1'b1;
    @(negedge clk_sys);
    check_eq("disk read odd", 32'(16'h5a5a), 32'(cpu_rdata_o));
    step();
    cpu_addr_i = 22'h12344;
    @(negedge clk_sys);
    check_eq("disk read even", 32'(16'ha5a5), 32'(cpu_rdata_o));
    step();
    dsk_ack_i = 1'b0;
    cpu_ram_oe_n_i = 1'b1;

    // Turbo behind four SD transfers
    turbo_req_i = 1'b1;
    dl_slot_i = 1'b1;
    for (int k = 0; k < 4; k++) begin
      step();
      sd_ack_i = 1'b1;
      step();
      sd_ack_i = 1'b0;
      @(negedge clk_sys);
      check_eq("turbo before ack count", 32'(1'b0), 32'(turbo_o));
    end
    n = 0;
    while (turbo_o !== 1'b1) begin
      @(negedge clk_sys);
      n++;
      if (n > 10) timeout_fail("turbo enable");
    end
    step();
    turbo_req_i = 1'b0;
    n = 0;
    while (turbo_o !== 1'b0) begin
      @(negedge clk_sys);
      n++;
      if (n > 10) timeout_fail("turbo to follow request");
    end
    step();
    turbo_req_i = 1'b1;
    n = 0;
    while (turbo_o !== 1'b1) begin
      @(negedge clk_sys);
      n++;
      if (n > 10) timeout_fail("turbo to return");
    end

    // Reset request drops turbo
    step();
    reset_req_i = 1'b1;
    n = 0;
    while (turbo_o !== 1'b0) begin
      @(negedge clk_sys);
      n++;
      if (n > 10) timeout_fail("turbo drop on reset request");
    end
    check_eq("reset during request", 32'(1'b0), 32'(sys_reset_n_o));
    step();
    reset_req_i = 1'b0;
    wait_reset_release("reset release after request");
    check_eq("turbo after reset", 32'(1'b0), 32'(turbo_o));

    // Motor clears the delay at once
    step();
    disk_motor_i = 1'b1;
    n = 0;
    while (turbo_o !== 1'b1) begin
      @(negedge clk_sys);
      n++;
      if (n > 4) timeout_fail("turbo on disk motor");
    end

    // Activity LED against the motor and download state
    @(negedge clk_sys);
    check_eq("led with motor only", 32'(1'b1), 32'(led_o));
    step();
    disk_act_i = 1'b1;
    step();
    disk_act_i = 1'b0;
    n = 0;
    while (led_o !== 1'b0) begin
      @(negedge clk_sys);
      n++;
      if (n > 4) timeout_fail("LED activity against motor");
    end
    step();
    dl_active_i = 1'b1;
    @(negedge clk_sys);
    check_eq("led during download", 32'(1'b1), 32'(led_o));
    step();
    dl_active_i = 1'b0;
    disk_motor_i = 1'b0;
    @(negedge clk_sys);
    check_eq("led activity only", 32'(1'b1), 32'(led_o));

    if (n_checks > 0) begin
      $display("all tests passed");
    end else begin
      $display("No checks ran");
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tests/loader_input.txt */
// Header: loader vector count, presence vector count
// Loader: index, even byte addr, byte0, byte1, expected SDRAM addr, expected word
// Presence: index, final byte addr, 0, 0, 0, expected {ds[1:0], ss[1:0]}
00000004 00000002
00000000 00000010 0000003c 0000005a 00200008 00003c5a
00000001 00000100 000000a1 000000b2 00280080 0000a1b2
00000002 00001000 000000de 000000ad 00300800 0000dead
00000001 000ffffe 00000001 000000fe 002fffff 000001fe
00000001 000c8000 00000000 00000000 00000000 00000004
00000002 00064000 00000000 00000000 00000000 00000006

/* vlog.f */
design/mac_glue_pkg.sv
design/mem_req_if.sv
design/clk_reset_gen.sv
design/image_loader.sv
design/disk_presence.sv
design/sdram_mux.sv
design/turbo_gate.sv
design/mac_glue_top.sv
tests/tb_clk_gen.sv
tests/tb_mac_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the glue subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_mac_glue -o tb_mac_glue > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_mac_glue > sim.log 2>&1 || echo "Simulator returned an error"

grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "No pass report"; exit 1; }
echo "Simulation passed"
